/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = udp_tx_tb
FILELIST = filelist.f
OBJ_DIR = obj_dir
LOG = sim.log
FAIL_PATTERN = SIMULATION FAILED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, log in $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_PATTERN)" $(LOG); then \
		echo "Test run failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* filelist.f */
+incdir+verilog
verilog/udp_tx_pkg.sv
verilog/crc_if.sv
verilog/udp_frame_builder.sv
verilog/crc32_nibble.sv
verilog/mii_tx_serializer.sv
verilog/udp_tx_top.sv
sim/udp_tx_tb.sv

/* sim/udp_tx_tb.sv */
`include "udp_tx_defs.svh"

module udp_tx_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int BURST_NIBBLES = `PREAMBLE_NIBBLES + `FRAME_BYTES * 2 + `FCS_NIBBLES;
    localparam int FRAME_COUNT = 4;
    localparam int WAIT_LIMIT = 2000;
    // Top bit of the IPv4 header inside a frame vector
    localparam int IP_MSB = (`FRAME_BYTES - `MAC_HEADER_BYTES) * 8 - 1;

    // First byte on the wire in the top byte
    typedef logic [`FRAME_BYTES*8-1:0] frame_vec_t;

    logic clk = 1'b0;
    logic reset;
    logic send;
    udp_tx_pkg::payload_t payload;
    udp_tx_pkg::mac_addr_t src_mac;
    udp_tx_pkg::mac_addr_t dest_mac;
    udp_tx_pkg::ipv4_addr_t src_ip;
    udp_tx_pkg::ipv4_addr_t dest_ip;
    udp_tx_pkg::udp_port_t src_port;
    udp_tx_pkg::udp_port_t dest_port;
    logic ready;
    logic tx_en;
    udp_tx_pkg::nibble_t tx_d;

    // Monitor bookkeeping
    int errors = 0;
    int accepted = 0;
    int bursts = 0;
    int bursts_checked = 0;
    int idle_cycles = 0;
    logic tx_en_q = 1'b0;
    logic reset_edge = 1'b1;
    logic reset_edge_q = 1'b1;
    logic [3:0] burst_q[$];

    // Stimulus bookkeeping
    int run_errors = 0;
    int frames_sent = 0;
    bit timed_out = 1'b0;
    logic [31:0] lcg_state = 32'd45;
    frame_vec_t expected_frames [FRAME_COUNT];

    udp_tx_top DUT (.*);

    // 4 ns period
    always #2 clk = ~clk;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Expected frame built byte by byte from the fields now on the inputs
    function automatic frame_vec_t model_frame();
        logic [7:0] b [`FRAME_BYTES];
        logic [31:0] sum;
        frame_vec_t f;
        int ip_len;
        ip_len = `IP_HEADER_BYTES + `UDP_HEADER_BYTES + `UDP_PAYLOAD_BYTES;
        // Zero fields and pad stay as cleared here
        for (int i = 0; i < `FRAME_BYTES; i++) begin
            b[i] = 8'h00;
        end
        for (int i = 0; i < 6; i++) begin
            b[i] = dest_mac[47 - 8 * i -: 8];
            b[6 + i] = src_mac[47 - 8 * i -: 8];
        end
        // EtherType 0800, then version 4 with IHL 5
        b[12] = 8'h08;
        b[14] = 8'h45;
        b[15] = `IP_TOS;
        b[17] = 8'(ip_len);
        b[22] = `IP_TTL;
        b[23] = `IP_PROTO_UDP;
        for (int i = 0; i < 4; i++) begin
            b[26 + i] = src_ip[31 - 8 * i -: 8];
            b[30 + i] = dest_ip[31 - 8 * i -: 8];
        end
        b[34] = src_port[15:8];
        b[35] = src_port[7:0];
        b[36] = dest_port[15:8];
        b[37] = dest_port[7:0];
        b[39] = 8'(ip_len - `IP_HEADER_BYTES);
        // Payload follows the 42 header bytes
        for (int i = 0; i < `UDP_PAYLOAD_BYTES; i++) begin
            b[42 + i] = payload[`UDP_PAYLOAD_BYTES * 8 - 1 - 8 * i -: 8];
        end
        // Ones' complement sum of the header words with the checksum still zero
        sum = 32'd0;
        for (int i = 14; i < 34; i += 2) begin
            sum += {16'h0, b[i], b[i + 1]};
        end
        while (sum[31:16] != 16'h0) begin
            sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
        end
        b[24] = ~sum[15:8];
        b[25] = ~sum[7:0];
        for (int i = 0; i < `FRAME_BYTES; i++) begin
            f[(`FRAME_BYTES - 1 - i) * 8 +: 8] = b[i];
        end
        return f;
    endfunction

    // Folded sum of all ten header words is all ones when the checksum is right
    function automatic logic [15:0] header_sum(input frame_vec_t f);
        logic [31:0] sum;
        sum = 32'd0;
        for (int i = 0; i < `IP_HEADER_BYTES / 2; i++) begin
            sum += {16'h0, f[IP_MSB - 16 * i -: 16]};
        end
        while (sum[31:16] != 16'h0) begin
            sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
        end
        return sum[15:0];
    endfunction

    // Reflected CRC-32 one bit at a time with each byte LSB first
    function automatic logic [31:0] frame_crc(input frame_vec_t f);
        logic [31:0] c;
        logic [7:0] d;
        c = 32'hFFFFFFFF;
        for (int i = 0; i < `FRAME_BYTES; i++) begin
            d = f[(`FRAME_BYTES - 1 - i) * 8 +: 8];
            for (int k = 0; k < 8; k++) begin
                c = (c[0] ^ d[k]) ? (c >> 1) ^ 32'hEDB88320 : c >> 1;
            end
        end
        return ~c;
    endfunction

    task automatic expect_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("Fail at %0d ns: %s expected %0h got %0h", $time, name, expected, actual);
        end
    endtask

    // One finished tx_en burst against the next expected frame
    task automatic check_burst();
        frame_vec_t rx_frame;
        frame_vec_t exp_frame;
        logic [31:0] exp_crc;
        expect_value("tx_en burst length", BURST_NIBBLES, burst_q.size());
        if (bursts_checked >= frames_sent) begin
            errors++;
            $display("A burst on tx_en ended at %0d ns with no frame sent for it", $time);
        end else if (burst_q.size() == BURST_NIBBLES) begin
            exp_frame = expected_frames[bursts_checked];
            // Fifteen 5 nibbles, then the SFD nibble
            for (int i = 0; i < `PREAMBLE_NIBBLES; i++) begin
                expect_value($sformatf("tx_d preamble nibble %0d", i),
                    (i == `PREAMBLE_NIBBLES - 1) ? 32'hD : 32'h5, 32'(burst_q[i]));
            end
            // Low nibble of each byte comes first
            for (int i = 0; i < `FRAME_BYTES; i++) begin
                rx_frame[(`FRAME_BYTES - 1 - i) * 8 +: 8] =
                    {burst_q[`PREAMBLE_NIBBLES + 2 * i + 1], burst_q[`PREAMBLE_NIBBLES + 2 * i]};
            end
            assert (rx_frame == exp_frame) else begin
                errors++;
                $display("Fail at %0d ns: frame %0d expected %h got %h",
                    $time, bursts_checked, exp_frame, rx_frame);
            end
            expect_value("IPv4 header sum", 32'hFFFF, 32'(header_sum(rx_frame)));
            // FCS goes LSB byte first, low nibble first
            exp_crc = frame_crc(exp_frame);
            for (int i = 0; i < `FCS_NIBBLES; i++) begin
                expect_value($sformatf("tx_d FCS nibble %0d", i), 32'(exp_crc[4 * i +: 4]),
                    32'(burst_q[BURST_NIBBLES - `FCS_NIBBLES + i]));
            end
        end
        bursts_checked++;
        burst_q.delete();
    endtask

    // Inputs as the DUT sees them on the rising edge
    always @(posedge clk) begin
        reset_edge_q = reset_edge;
        reset_edge = reset;
        if (send && ready && !reset) begin
            accepted++;
        end
    end

    // Outputs are stable on the falling edge
    always @(negedge clk) begin
        if (reset_edge) begin
            expect_value("tx_en in reset", 0, 32'(tx_en));
            expect_value("tx_d in reset", 0, 32'(tx_d));
            expect_value("ready in reset", 0, 32'(ready));
        end else if (reset_edge_q) begin
            expect_value("ready after reset", 1, 32'(ready));
        end
        if (tx_en === 1'b1) begin
            if (!tx_en_q) begin
                assert (accepted > bursts) else begin
                    errors++;
                    $display("tx_en rose at %0d ns with no accepted frame", $time);
                end
                if (bursts > 0) begin
                    assert (idle_cycles >= `IFG_NIBBLES) else begin
                        errors++;
                        $display("Fail at %0d ns: tx_en low cycles expected %0d or more got %0d",
                            $time, `IFG_NIBBLES, idle_cycles);
                    end
                end
                bursts++;
            end
            burst_q.push_back(tx_d);
            // A frame accepted beyond the one on the wire sits in the builder
            if (accepted > bursts) begin
                expect_value("ready while a frame waits", 0, 32'(ready));
            end
            idle_cycles = 0;
        end else begin
            if (tx_en_q) begin
                check_burst();
            end
            idle_cycles++;
        end
        tx_en_q = (tx_en === 1'b1);
    end

    // One cycle of a bounded wait
    task automatic wait_cycle(input string what, inout int waited);
        @(negedge clk);
        waited++;
        if (waited > WAIT_LIMIT) begin
            timed_out = 1'b1;
            run_errors++;
            $display("Timeout at %0d ns while waiting for %s", $time, what);
        end
    endtask

    // send stays high and fresh fields follow every acceptance
    task automatic send_frames();
        logic [31:0] r [12];
        int waited;
        for (int n = 0; n < FRAME_COUNT && !timed_out; n++) begin
            for (int i = 0; i < 12; i++) begin
                r[i] = next_random();
            end
            dest_mac = {r[0], r[1][15:0]};
            src_mac = {r[2], r[3][15:0]};
            src_ip = r[4];
            dest_ip = r[5];
            src_port = r[6][15:0];
            dest_port = r[7][15:0];
            payload = {r[8], r[9], r[10], r[11]};
            send = 1'b1;
            expected_frames[n] = model_frame();
            frames_sent++;
            waited = 0;
            // Low while the previous frame waits for the serializer
            while (!ready && !timed_out) begin
                wait_cycle("ready", waited);
            end
            // Acceptance edge lies before this falling edge
            @(negedge clk);
        end
        send = 1'b0;
    endtask

    initial begin
        int waited;
        reset = 1'b1;
        send = 1'b0;
        payload = '0;
        src_mac = '0;
        dest_mac = '0;
        src_ip = '0;
        dest_ip = '0;
        src_port = '0;
        dest_port = '0;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        send_frames();
        waited = 0;
        while (bursts_checked < FRAME_COUNT && !timed_out) begin
            wait_cycle("all bursts on tx_en", waited);
        end
        // No extra burst may show up in the quiet period
        repeat (2 * `IFG_NIBBLES) @(negedge clk);
        assert (bursts == FRAME_COUNT) else begin
            run_errors++;
            $display("Fail at %0d ns: bursts expected %0d got %0d", $time, FRAME_COUNT, bursts);
        end
        $display("Bursts checked %0d of %0d, monitor errors %0d, run errors %0d",
            bursts_checked, FRAME_COUNT, errors, run_errors);
        if (errors + run_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* verilog/crc32_nibble.sv */
`include "udp_tx_defs.svh"

module crc32_nibble (
    input logic clk,
    input logic reset,
    crc_if.unit crc
);

    udp_tx_pkg::crc_t crc_reg;

    // Four bits of reflected CRC-32, nibble bit 0 goes in first
    function automatic udp_tx_pkg::crc_t crc_step(
        input udp_tx_pkg::crc_t  value,
        input udp_tx_pkg::nibble_t data
    );
        udp_tx_pkg::crc_t next;
        next = value;
        for (int i = 0; i < 4; i++) begin
            if (next[0] ^ data[i]) begin
                next = (next >> 1) ^ `CRC_POLY;
            end else begin
                next = next >> 1;
            end
        end
        return next;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            crc_reg <= `CRC_INIT;
        end else if (crc.init) begin
            crc_reg <= `CRC_INIT;
        end else if (crc.enable) begin
            crc_reg <= crc_step(crc_reg, crc.nibble);
        end
    end

    // Raw register, complement is done by the serializer
    assign crc.crc = crc_reg;

endmodule

/* verilog/crc_if.sv */
interface crc_if;
    // Load the initial value on the next edge
    logic init;
    // Fold the nibble in on the next edge
    logic enable;
    udp_tx_pkg::nibble_t nibble;
    // Current register value
    udp_tx_pkg::crc_t crc;

    // Serializer side
    modport ctrl (
        output init, enable, nibble,
        input crc
    );

    // CRC unit side
    modport unit (
        input init, enable, nibble,
        output crc
    );
endinterface

/* verilog/mii_tx_serializer.sv */
`include "udp_tx_defs.svh"

module mii_tx_serializer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 frame_valid,
    input  udp_tx_pkg::frame_t   frame,
    output logic                 frame_take,
    output logic                 tx_en,
    output udp_tx_pkg::nibble_t  tx_d,
    crc_if.ctrl                  crc
);

    localparam int FRAME_BITS = `FRAME_BYTES * 8;
    localparam int FRAME_NIBBLES = `FRAME_BYTES * 2;

    // Preamble byte 55 and SFD byte D5, low nibble first
    localparam udp_tx_pkg::nibble_t PREAMBLE_NIBBLE = 4'h5;
    localparam udp_tx_pkg::nibble_t SFD_NIBBLE = 4'hD;

    // Last count value of each phase
    localparam logic [7:0] PREAMBLE_LAST = 8'(`PREAMBLE_NIBBLES - 1);
    localparam logic [7:0] FRAME_LAST = 8'(FRAME_NIBBLES - 1);
    localparam logic [7:0] FCS_LAST = 8'(`FCS_NIBBLES - 1);
    localparam logic [7:0] GAP_LAST = 8'(`IFG_NIBBLES - 1);

    udp_tx_pkg::tx_state_t state;
    logic [7:0] count;

    // Local copy, shifted up one byte per two nibbles
    udp_tx_pkg::frame_t frame_q;

    udp_tx_pkg::nibble_t frame_nibble;
    udp_tx_pkg::nibble_t fcs_nibble;
    udp_tx_pkg::crc_t    fcs_word;

    // Top byte is the current one, low nibble on even counts
    assign frame_nibble = count[0] ? frame_q[FRAME_BITS-1 -: 4] : frame_q[FRAME_BITS-5 -: 4];

    // FCS goes out LSB byte first, low nibble first
    assign fcs_word = ~crc.crc;
    assign fcs_nibble = fcs_word[{count[2:0], 2'b00} +: 4];

    assign frame_take = (state == udp_tx_pkg::IDLE) && frame_valid;

    // CRC restarts during the preamble and folds every frame nibble
    assign crc.init = (state == udp_tx_pkg::PREAMBLE);
    assign crc.enable = (state == udp_tx_pkg::FRAME);
    assign crc.nibble = frame_nibble;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= udp_tx_pkg::IDLE;
            count <= '0;
            tx_en <= 1'b0;
            tx_d <= '0;
        end else begin
            case (state)
                udp_tx_pkg::IDLE: begin
                    tx_en <= 1'b0;
                    tx_d <= '0;
                    if (frame_take) begin
                        state <= udp_tx_pkg::PREAMBLE;
                        count <= '0;
                    end
                end
                udp_tx_pkg::PREAMBLE: begin
                    tx_en <= 1'b1;
                    tx_d <= (count == PREAMBLE_LAST) ? SFD_NIBBLE : PREAMBLE_NIBBLE;
                    if (count == PREAMBLE_LAST) begin
                        state <= udp_tx_pkg::FRAME;
                        count <= '0;
                    end else begin
                        count <= count + 8'd1;
                    end
                end
                udp_tx_pkg::FRAME: begin
                    tx_en <= 1'b1;
                    tx_d <= frame_nibble;
                    if (count == FRAME_LAST) begin
                        state <= udp_tx_pkg::FCS;
                        count <= '0;
                    end else begin
                        count <= count + 8'd1;
                    end
                end
                udp_tx_pkg::FCS: begin
                    // CRC register holds during this phase
                    tx_en <= 1'b1;
                    tx_d <= fcs_nibble;
                    if (count == FCS_LAST) begin
                        state <= udp_tx_pkg::GAP;
                        count <= '0;
                    end else begin
                        count <= count + 8'd1;
                    end
                end
                udp_tx_pkg::GAP: begin
                    tx_en <= 1'b0;
                    tx_d <= '0;
                    if (count == GAP_LAST) begin
                        state <= udp_tx_pkg::IDLE;
                        count <= '0;
                    end else begin
                        count <= count + 8'd1;
                    end
                end
                default: state <= udp_tx_pkg::IDLE;
            endcase
        end
    end

    // Frame copy, builder is free to refill right after take
    always_ff @(posedge clk) begin
        if (frame_take) begin
            frame_q <= frame;
        end else if (state == udp_tx_pkg::FRAME && count[0]) begin
            frame_q <= frame_q << 8;
        end
    end

endmodule

/* verilog/udp_frame_builder.sv */
`include "udp_tx_defs.svh"

module udp_frame_builder (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   send,
    input  udp_tx_pkg::payload_t   payload,
    input  udp_tx_pkg::mac_addr_t  src_mac,
    input  udp_tx_pkg::mac_addr_t  dest_mac,
    input  udp_tx_pkg::ipv4_addr_t src_ip,
    input  udp_tx_pkg::ipv4_addr_t dest_ip,
    input  udp_tx_pkg::udp_port_t  src_port,
    input  udp_tx_pkg::udp_port_t  dest_port,
    input  logic                   frame_take,
    output logic                   ready,
    output logic                   frame_valid,
    output udp_tx_pkg::frame_t     frame
);

    // Length fields
    localparam int UDP_TOTAL_BYTES = `UDP_HEADER_BYTES + `UDP_PAYLOAD_BYTES;
    localparam int IP_TOTAL_BYTES = `IP_HEADER_BYTES + UDP_TOTAL_BYTES;

    // IPv4 header position inside the frame
    localparam int IP_MSB = (`FRAME_BYTES - `MAC_HEADER_BYTES) * 8 - 1;
    localparam int IP_WORDS = `IP_HEADER_BYTES / 2;
    // Checksum is the sixth header word
    localparam int CSUM_MSB = IP_MSB - 16 * 5;

    udp_tx_pkg::build_state_t state;

    // Ten words of at most FFFF fit in 20 bits
    logic [19:0] word_sum;
    logic [19:0] sum;
    logic [16:0] fold_one;
    logic [15:0] fold_two;
    logic [15:0] csum;
    logic        accept;

    assign accept = send && ready;

    // Header word sum, checksum field is still zero here
    always_comb begin
        word_sum = '0;
        for (int i = 0; i < IP_WORDS; i++) begin
            word_sum = word_sum + 20'(frame[IP_MSB - 16 * i -: 16]);
        end
    end

    // Two carry folds, then ones' complement
    always_comb begin
        fold_one = {1'b0, sum[15:0]} + {13'b0, sum[19:16]};
        fold_two = fold_one[15:0] + 16'(fold_one[16]);
        csum = ~fold_two;
    end

    // Control
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= udp_tx_pkg::EMPTY;
            ready <= 1'b0;
            frame_valid <= 1'b0;
        end else begin
            case (state)
                udp_tx_pkg::EMPTY: begin
                    if (accept) begin
                        state <= udp_tx_pkg::SUM;
                        ready <= 1'b0;
                    end else begin
                        // Comes up one edge after reset release
                        ready <= 1'b1;
                    end
                end
                udp_tx_pkg::SUM: state <= udp_tx_pkg::FOLD;
                udp_tx_pkg::FOLD: state <= udp_tx_pkg::FULL;
                udp_tx_pkg::FULL: begin
                    if (frame_take) begin
                        state <= udp_tx_pkg::EMPTY;
                        ready <= 1'b1;
                        frame_valid <= 1'b0;
                    end else begin
                        // Valid follows the checksum write by one cycle
                        frame_valid <= 1'b1;
                    end
                end
                default: state <= udp_tx_pkg::EMPTY;
            endcase
        end
    end

    // Frame contents and checksum accumulator
    always_ff @(posedge clk) begin
        if (accept) begin
            frame <= {
                dest_mac, src_mac, `ETHER_TYPE_IPV4,
                4'd4, 4'd5, `IP_TOS, 16'(IP_TOTAL_BYTES),
                // Identification, flags and fragment offset
                16'h0000, 16'h0000,
                `IP_TTL, `IP_PROTO_UDP,
                // Header checksum, filled in FOLD
                16'h0000,
                src_ip, dest_ip,
                src_port, dest_port, 16'(UDP_TOTAL_BYTES),
                // UDP checksum unused
                16'h0000,
                payload,
                {(`PAD_BYTES * 8){1'b0}}
            };
        end else if (state == udp_tx_pkg::FOLD) begin
            frame[CSUM_MSB -: 16] <= csum;
        end
        if (state == udp_tx_pkg::SUM) begin
            sum <= word_sum;
        end
    end

endmodule

/* verilog/udp_tx_defs.svh */
`ifndef UDP_TX_DEFS_SVH
`define UDP_TX_DEFS_SVH

// UDP payload carried by every frame
`define UDP_PAYLOAD_BYTES 16

// Header sizes
`define MAC_HEADER_BYTES 14
`define IP_HEADER_BYTES 20
`define UDP_HEADER_BYTES 8

// Zero bytes after the payload to reach a multiple of four bytes
`define PAD_BYTES \
    ((4 - ((`MAC_HEADER_BYTES + `IP_HEADER_BYTES + `UDP_HEADER_BYTES + \
    `UDP_PAYLOAD_BYTES) % 4)) % 4)

// Whole frame without the FCS
`define FRAME_BYTES \
    (`MAC_HEADER_BYTES + `IP_HEADER_BYTES + `UDP_HEADER_BYTES + \
    `UDP_PAYLOAD_BYTES + `PAD_BYTES)

// Nibble counts on the MII side
`define PREAMBLE_NIBBLES 16
`define FCS_NIBBLES 8
// Idle cycles between frames
`define IFG_NIBBLES 24

// Protocol field values
`define ETHER_TYPE_IPV4 16'h0800
`define IP_TOS 8'h0C
`define IP_TTL 8'hFF
`define IP_PROTO_UDP 8'h11

// Ethernet CRC-32, reflected form of 04C11DB7
`define CRC_POLY 32'hEDB88320
`define CRC_INIT 32'hFFFFFFFF

`endif

/* verilog/udp_tx_pkg.sv */
`include "udp_tx_defs.svh"

package udp_tx_pkg;

    // Addressing fields
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ipv4_addr_t;
    typedef logic [15:0] udp_port_t;

    // Payload, first byte in the top byte
    typedef logic [`UDP_PAYLOAD_BYTES*8-1:0] payload_t;

    // Assembled frame, first byte on the wire in the top byte
    typedef logic [`FRAME_BYTES*8-1:0] frame_t;

    // One MII transfer
    typedef logic [3:0] nibble_t;

    // Running CRC register
    typedef logic [31:0] crc_t;

    // Builder holds at most one frame
    typedef enum logic [1:0] {
        EMPTY,
        SUM,
        FOLD,
        FULL
    } build_state_t;

    // Wire sequence of one frame
    typedef enum logic [2:0] {
        IDLE,
        PREAMBLE,
        FRAME,
        FCS,
        GAP
    } tx_state_t;

endpackage

/* verilog/udp_tx_top.sv */
module udp_tx_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   send,
    input  udp_tx_pkg::payload_t   payload,
    input  udp_tx_pkg::mac_addr_t  src_mac,
    input  udp_tx_pkg::mac_addr_t  dest_mac,
    input  udp_tx_pkg::ipv4_addr_t src_ip,
    input  udp_tx_pkg::ipv4_addr_t dest_ip,
    input  udp_tx_pkg::udp_port_t  src_port,
    input  udp_tx_pkg::udp_port_t  dest_port,
    output logic                   ready,
    output logic                   tx_en,
    output udp_tx_pkg::nibble_t    tx_d
);

    // Builder to serializer handoff
    logic               frame_valid;
    logic               frame_take;
    udp_tx_pkg::frame_t frame;

    // Serializer to CRC unit
    crc_if crc_bus ();

    // Latch, assemble and checksum one frame
    udp_frame_builder u_builder (
        .clk         (clk),
        .reset       (reset),
        .send        (send),
        .payload     (payload),
        .src_mac     (src_mac),
        .dest_mac    (dest_mac),
        .src_ip      (src_ip),
        .dest_ip     (dest_ip),
        .src_port    (src_port),
        .dest_port   (dest_port),
        .frame_take  (frame_take),
        .ready       (ready),
        .frame_valid (frame_valid),
        .frame       (frame)
    );

    // Preamble, frame, FCS and gap on the MII
    mii_tx_serializer u_serializer (
        .clk         (clk),
        .reset       (reset),
        .frame_valid (frame_valid),
        .frame       (frame),
        .frame_take  (frame_take),
        .tx_en       (tx_en),
        .tx_d        (tx_d),
        .crc         (crc_bus.ctrl)
    );

    // Running FCS
    crc32_nibble u_crc (
        .clk   (clk),
        .reset (reset),
        .crc   (crc_bus.unit)
    );

endmodule
